// File: logic/video_pkg.sv
package video_pkg;

	// Row, column and frame size counters
	localparam int DIM_WIDTH = 12;

	localparam int PIXEL_WIDTH_DEFAULT = 8;

	// Stream sideband bits carried next to the pixel (tuser and tlast)
	localparam int SIDEBAND_WIDTH = 2;

	typedef logic [DIM_WIDTH-1:0] dim_t;

endpackage

// File: logic/bayer_pkg.sv
package bayer_pkg;

	// Row parity in the upper bit and column parity in the lower bit
	typedef enum logic [1:0] {
		SITE_EVEN_EVEN = 2'b00,
		SITE_EVEN_ODD  = 2'b01,
		SITE_ODD_EVEN  = 2'b10,
		SITE_ODD_ODD   = 2'b11
	} bayer_site_t;

	// Row parity of the kept site
	function automatic logic site_row_odd(input bayer_site_t site);
		return site[1];
	endfunction

	function automatic logic site_col_odd(input bayer_site_t site);
		return site[0]; // Column parity
	endfunction

endpackage

// File: logic/axis_register_slice.sv
`timescale 1ns/1ps

module axis_register_slice #(
	parameter int PIXEL_WIDTH = video_pkg::PIXEL_WIDTH_DEFAULT
) (
	input  logic                   clk,
	input  logic                   resetn,
	input  logic [PIXEL_WIDTH-1:0] in_tdata,
	input  logic                   in_tuser,
	input  logic                   in_tlast,
	input  logic                   in_tvalid,
	output logic                   in_tready,
	output logic [PIXEL_WIDTH-1:0] out_tdata,
	output logic                   out_tuser,
	output logic                   out_tlast,
	output logic                   out_tvalid,
	input  logic                   out_tready
);
	import video_pkg::*;

	localparam int BEAT_WIDTH = PIXEL_WIDTH + SIDEBAND_WIDTH;

	logic [BEAT_WIDTH-1:0] in_beat;
	logic [BEAT_WIDTH-1:0] main_beat;
	logic [BEAT_WIDTH-1:0] skid_beat;
	logic                  skid_valid;
	logic                  skid_valid_next;
	logic                  in_fire;
	logic                  main_free;

	assign in_beat = {in_tuser, in_tlast, in_tdata};
	assign {out_tuser, out_tlast, out_tdata} = main_beat;

	assign in_fire = in_tvalid && in_tready;
	assign main_free = !out_tvalid || out_tready;

	// Skid entry fills when a beat lands on a stalled main register
	assign skid_valid_next = skid_valid ? !main_free : (in_fire && !main_free);

	always_ff @(posedge clk) begin
		if (!resetn) begin
			out_tvalid <= 1'b0;
			skid_valid <= 1'b0;
			in_tready  <= 1'b0;
		end else begin
			if (main_free)
				out_tvalid <= skid_valid || in_fire;
			skid_valid <= skid_valid_next;
			in_tready  <= !skid_valid_next; // Registered ready
		end
	end

	always_ff @(posedge clk) begin
		if (main_free) begin
			if (skid_valid)
				main_beat <= skid_beat; // Drain skid first to keep order
			else if (in_fire)
				main_beat <= in_beat;
		end
		if (in_fire && !main_free)
			skid_beat <= in_beat;
	end

	// Held beat must not move until it is taken
	assert property (@(posedge clk) disable iff (!resetn)
		out_tvalid && !out_tready |=> out_tvalid && $stable(main_beat));

endmodule

// File: logic/axis_bayer_extractor.sv
`timescale 1ns/1ps

module axis_bayer_extractor #(
	parameter int                    PIXEL_WIDTH = video_pkg::PIXEL_WIDTH_DEFAULT,
	parameter bayer_pkg::bayer_site_t SITE        = bayer_pkg::SITE_ODD_EVEN
) (
	input  logic                   clk,
	input  logic                   resetn,
	input  logic [PIXEL_WIDTH-1:0] s_axis_tdata,
	input  logic                   s_axis_tuser,
	input  logic                   s_axis_tlast,
	input  logic                   s_axis_tvalid,
	output logic                   s_axis_tready,
	output logic [PIXEL_WIDTH-1:0] m_axis_tdata,
	output logic                   m_axis_tuser,
	output logic                   m_axis_tlast,
	output logic                   m_axis_tvalid,
	input  logic                   m_axis_tready
);
	import video_pkg::*;
	import bayer_pkg::*;

	localparam logic KEEP_ROW = site_row_odd(SITE);
	localparam logic KEEP_COL = site_col_odd(SITE);

	// Position of the next input beat
	dim_t row;
	dim_t col;
	dim_t cur_row;
	dim_t cur_col;

	logic s_fire;
	logic keep;
	logic out_free;
	logic emit;
	logic emit_last;
	logic sof_pending;

	// One kept pixel waiting to learn whether it ends its line
	logic                   pend_valid;
	logic                   pend_user;
	logic                   pend_eol;
	logic [PIXEL_WIDTH-1:0] pend_data;

	assign s_fire = s_axis_tvalid && s_axis_tready;
	assign out_free = !m_axis_tvalid || m_axis_tready;

	// Stall while output is blocked or a line end still has to go out
	assign s_axis_tready = out_free && !(pend_valid && pend_eol);

	// Frame start puts this beat at the origin
	assign cur_row = s_axis_tuser ? '0 : row;
	assign cur_col = s_axis_tuser ? '0 : col;

	assign keep = (cur_row[0] == KEEP_ROW) && (cur_col[0] == KEEP_COL);

	// Pending pixel leaves on the next kept pixel or on the line end
	assign emit = pend_valid && out_free &&
		(pend_eol || (s_fire && (keep || s_axis_tlast)));
	assign emit_last = pend_eol || !keep;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			row <= '0;
			col <= '0;
		end else if (s_fire) begin
			if (s_axis_tlast) begin
				row <= cur_row + 1'b1;
				col <= '0;
			end else begin
				row <= cur_row;
				col <= cur_col + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			pend_valid  <= 1'b0;
			pend_user   <= 1'b0;
			pend_eol    <= 1'b0;
			sof_pending <= 1'b0;
		end else begin
			if (s_fire && keep) begin
				pend_valid <= 1'b1;
				pend_user  <= s_axis_tuser || sof_pending;
				pend_eol   <= s_axis_tlast; // Kept pixel closes its own line
			end else if (emit) begin
				pend_valid <= 1'b0;
				pend_eol   <= 1'b0;
			end

			// Frame start rides along until a pixel is kept
			if (s_fire)
				sof_pending <= keep ? 1'b0 : (s_axis_tuser || sof_pending);
		end
	end

	always_ff @(posedge clk) begin
		if (s_fire && keep)
			pend_data <= s_axis_tdata;
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			m_axis_tvalid <= 1'b0;
			m_axis_tuser  <= 1'b0;
			m_axis_tlast  <= 1'b0;
		end else if (emit) begin
			m_axis_tvalid <= 1'b1;
			m_axis_tuser  <= pend_user;
			m_axis_tlast  <= emit_last;
		end else if (m_axis_tready) begin
			m_axis_tvalid <= 1'b0;
			m_axis_tuser  <= 1'b0;
			m_axis_tlast  <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (emit)
			m_axis_tdata <= pend_data;
	end

	// No kept pixel may overrun a pending pixel that cannot leave
	assert property (@(posedge clk) disable iff (!resetn)
		s_fire && keep |-> !(pend_valid && m_axis_tvalid && !m_axis_tready));

	assert property (@(posedge clk) disable iff (!resetn)
		m_axis_tuser || m_axis_tlast |-> m_axis_tvalid);

endmodule

// File: logic/bayer_frame_monitor.sv
`timescale 1ns/1ps

module bayer_frame_monitor (
	input  logic                             clk,
	input  logic                             resetn,
	input  logic                             tvalid,
	input  logic                             tready,
	input  logic                             tuser,
	input  logic                             tlast,
	output logic [video_pkg::DIM_WIDTH-1:0] frame_width,
	output logic [video_pkg::DIM_WIDTH-1:0] frame_height,
	output logic                             frame_done,
	output logic                             size_error
);
	import video_pkg::*;

	dim_t beat_cnt;
	dim_t line_cnt;
	dim_t first_len;
	dim_t line_len;
	dim_t line_idx;
	logic fire;
	logic seen_frame;

	assign fire = tvalid && tready;

	// Counts as seen after this beat, restarted by a frame start
	assign line_len = (tuser ? '0 : beat_cnt) + 1'b1;
	assign line_idx = tuser ? '0 : line_cnt;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			beat_cnt     <= '0;
			line_cnt     <= '0;
			first_len    <= '0;
			seen_frame   <= 1'b0;
			frame_width  <= '0;
			frame_height <= '0;
			frame_done   <= 1'b0;
			size_error   <= 1'b0;
		end else begin
			frame_done <= fire && tuser && seen_frame; // None for the first frame

			if (fire) begin
				if (tuser) begin
					seen_frame   <= 1'b1;
					frame_width  <= first_len;
					frame_height <= line_cnt;
				end

				if (tlast) begin
					beat_cnt <= '0;
					line_cnt <= line_idx + 1'b1;
					// First line sets the reference length
					if (line_idx == '0)
						first_len <= line_len;
					else if (line_len != first_len)
						size_error <= 1'b1; // Sticky
				end else begin
					beat_cnt <= line_len;
					line_cnt <= line_idx;
				end
			end
		end
	end

	assert property (@(posedge clk) disable iff (!resetn)
		frame_done |=> !frame_done);

endmodule

// File: logic/bayer_extract_top.sv
`timescale 1ns/1ps

module bayer_extract_top #(
	parameter int                    PIXEL_WIDTH = video_pkg::PIXEL_WIDTH_DEFAULT,
	parameter bayer_pkg::bayer_site_t SITE        = bayer_pkg::SITE_ODD_EVEN
) (
	input  logic                             clk,
	input  logic                             resetn,
	input  logic [PIXEL_WIDTH-1:0]           s_axis_tdata,
	input  logic                             s_axis_tuser,
	input  logic                             s_axis_tlast,
	input  logic                             s_axis_tvalid,
	output logic                             s_axis_tready,
	output logic [PIXEL_WIDTH-1:0]           m_axis_tdata,
	output logic                             m_axis_tuser,
	output logic                             m_axis_tlast,
	output logic                             m_axis_tvalid,
	input  logic                             m_axis_tready,
	output logic [video_pkg::DIM_WIDTH-1:0] frame_width,
	output logic [video_pkg::DIM_WIDTH-1:0] frame_height,
	output logic                             frame_done,
	output logic                             size_error
);
	// Between slice and extractor
	logic [PIXEL_WIDTH-1:0] mid_tdata;
	logic                   mid_tuser;
	logic                   mid_tlast;
	logic                   mid_tvalid;
	logic                   mid_tready;

	axis_register_slice #(
		.PIXEL_WIDTH(PIXEL_WIDTH)
	) u_slice (
		.clk(clk),
		.resetn(resetn),
		.in_tdata(s_axis_tdata),
		.in_tuser(s_axis_tuser),
		.in_tlast(s_axis_tlast),
		.in_tvalid(s_axis_tvalid),
		.in_tready(s_axis_tready),
		.out_tdata(mid_tdata),
		.out_tuser(mid_tuser),
		.out_tlast(mid_tlast),
		.out_tvalid(mid_tvalid),
		.out_tready(mid_tready)
	);

	axis_bayer_extractor #(
		.PIXEL_WIDTH(PIXEL_WIDTH),
		.SITE(SITE)
	) u_extractor (
		.clk(clk),
		.resetn(resetn),
		.s_axis_tdata(mid_tdata),
		.s_axis_tuser(mid_tuser),
		.s_axis_tlast(mid_tlast),
		.s_axis_tvalid(mid_tvalid),
		.s_axis_tready(mid_tready),
		.m_axis_tdata(m_axis_tdata),
		.m_axis_tuser(m_axis_tuser),
		.m_axis_tlast(m_axis_tlast),
		.m_axis_tvalid(m_axis_tvalid),
		.m_axis_tready(m_axis_tready)
	);

	// Watches the extracted stream only
	bayer_frame_monitor u_monitor (
		.clk(clk),
		.resetn(resetn),
		.tvalid(m_axis_tvalid),
		.tready(m_axis_tready),
		.tuser(m_axis_tuser),
		.tlast(m_axis_tlast),
		.frame_width(frame_width),
		.frame_height(frame_height),
		.frame_done(frame_done),
		.size_error(size_error)
	);

endmodule

// File: tb/tb_bayer_extract.sv
`timescale 1ns/1ps

module tb_bayer_extract;
	import video_pkg::*;
	import bayer_pkg::*;

	localparam int PIXEL_WIDTH = 8;
	localparam logic [31:0] SEED = 32'ha98a_16b2;
	localparam int NUM_FRAMES = 6;

	// Input frame geometry with one short line in frame 4
	localparam int FRAME_W [NUM_FRAMES] = '{10, 10, 10, 7, 10, 10};
	localparam int FRAME_H [NUM_FRAMES] = '{10, 10, 10, 5, 10, 10};
	localparam int SHORT_ROW [NUM_FRAMES] = '{-1, -1, -1, -1, 3, -1};
	localparam int SHORT_W = 6;

	// Expected beat layout above the pixel bits
	localparam int LAST_BIT = PIXEL_WIDTH;
	localparam int USER_BIT = PIXEL_WIDTH + 1;
	localparam int BAD_BIT = PIXEL_WIDTH + 2;

	logic                   clk = 1'b0;
	logic                   resetn;
	logic [PIXEL_WIDTH-1:0] s_axis_tdata;
	logic                   s_axis_tuser;
	logic                   s_axis_tlast;
	logic                   s_axis_tvalid;
	logic                   s_axis_tready;
	logic [PIXEL_WIDTH-1:0] m_axis_tdata;
	logic                   m_axis_tuser;
	logic                   m_axis_tlast;
	logic                   m_axis_tvalid;
	logic                   m_axis_tready;
	dim_t                   frame_width;
	dim_t                   frame_height;
	logic                   frame_done;
	logic                   size_error;

	logic [31:0] rng;
	logic        reset_check;
	int          cycles = 0;
	int          n_pass = 0;
	int          n_fail = 0;
	int          err_site = 0;
	int          err_flags = 0;
	int          err_stall = 0;
	int          err_size = 0;
	int          err_ragged = 0;
	int          err_reset = 0;

	// Reference model with registered queue heads
	logic [BAD_BIT:0]       exp_q[$];
	logic [BAD_BIT:0]       exp_head;
	logic                   exp_avail = 1'b0;
	logic                   exp_err = 1'b0;
	logic [2*DIM_WIDTH-1:0] size_q[$];
	logic [2*DIM_WIDTH-1:0] size_head;
	logic                   size_avail = 1'b0;
	logic                   model_built = 1'b0;

	bayer_extract_top #(
		.PIXEL_WIDTH(PIXEL_WIDTH),
		.SITE(SITE_ODD_EVEN)
	) DUT (
		.clk(clk),
		.resetn(resetn),
		.s_axis_tdata(s_axis_tdata),
		.s_axis_tuser(s_axis_tuser),
		.s_axis_tlast(s_axis_tlast),
		.s_axis_tvalid(s_axis_tvalid),
		.s_axis_tready(s_axis_tready),
		.m_axis_tdata(m_axis_tdata),
		.m_axis_tuser(m_axis_tuser),
		.m_axis_tlast(m_axis_tlast),
		.m_axis_tvalid(m_axis_tvalid),
		.m_axis_tready(m_axis_tready),
		.frame_width(frame_width),
		.frame_height(frame_height),
		.frame_done(frame_done),
		.size_error(size_error)
	);

	always #50 clk = ~clk;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [PIXEL_WIDTH-1:0] pixel_value(input int r, input int c);
		return PIXEL_WIDTH'(r * 16 + c);
	endfunction

	function automatic int line_width(input int f, input int r);
		return (r == SHORT_ROW[f]) ? SHORT_W : FRAME_W[f];
	endfunction

	function automatic int total_pixels();
		int n;
		n = 0;
		for (int f = 0; f < NUM_FRAMES; f++)
			for (int r = 0; r < FRAME_H[f]; r++)
				n += line_width(f, r);
		return n;
	endfunction

	// Odd rows, even columns, ceil(W/2) wide and floor(H/2) high
	task automatic build_model();
		int   kw;
		int   first_kw;
		logic user;
		logic last;
		logic bad;
		for (int f = 0; f < NUM_FRAMES; f++) begin
			user = 1'b1;
			first_kw = (line_width(f, 1) + 1) / 2;
			for (int r = 1; r < FRAME_H[f]; r += 2) begin
				kw = (line_width(f, r) + 1) / 2;
				for (int c = 0; c < line_width(f, r); c += 2) begin
					last = (c + 2 >= line_width(f, r));
					bad = last && (kw != first_kw);
					exp_q.push_back({bad, user, last, pixel_value(r, c)});
					user = 1'b0;
				end
			end
			if (f < NUM_FRAMES - 1)
				size_q.push_back({dim_t'(first_kw), dim_t'(FRAME_H[f] / 2)}); // Reported at next start
		end
	endtask

	always @(posedge clk) begin
		if (!model_built) begin
			build_model();
			model_built = 1'b1;
		end
		if (resetn && m_axis_tvalid && m_axis_tready && exp_q.size() > 0) begin
			if (exp_q[0][BAD_BIT])
				exp_err <= 1'b1;
			void'(exp_q.pop_front());
		end
		if (resetn && frame_done && size_q.size() > 0)
			void'(size_q.pop_front());
		exp_avail <= exp_q.size() > 0;
		size_avail <= size_q.size() > 0;
		if (exp_q.size() > 0)
			exp_head <= exp_q[0];
		if (size_q.size() > 0)
			size_head <= size_q[0];
	end

	assert property (@(posedge clk) disable iff (!resetn)
		m_axis_tvalid && m_axis_tready |-> exp_avail)
		else begin
			err_site++;
			$display("site_select: extra output beat after all expected pixels");
		end

	assert property (@(posedge clk) disable iff (!resetn)
		m_axis_tvalid && m_axis_tready && exp_avail |-> m_axis_tdata == exp_head[PIXEL_WIDTH-1:0])
		else begin
			err_site++;
			$display("** Error site_select: expected %h, actual %h",
				$sampled(exp_head[PIXEL_WIDTH-1:0]), $sampled(m_axis_tdata));
		end

	assert property (@(posedge clk) disable iff (!resetn)
		m_axis_tvalid && m_axis_tready && exp_avail |->
			{m_axis_tuser, m_axis_tlast} == exp_head[USER_BIT:LAST_BIT])
		else begin
			err_flags++;
			$display("** Error flags: expected user/last %b, actual %b",
				$sampled(exp_head[USER_BIT:LAST_BIT]), $sampled({m_axis_tuser, m_axis_tlast}));
		end

	assert property (@(posedge clk) disable iff (!resetn)
		m_axis_tvalid && !m_axis_tready |=>
			m_axis_tvalid && $stable({m_axis_tdata, m_axis_tuser, m_axis_tlast}))
		else begin
			err_stall++;
			$display("backpressure: output beat changed or dropped while stalled");
		end

	assert property (@(posedge clk) disable iff (!resetn)
		frame_done |-> size_avail)
		else begin
			err_size++;
			$display("frame_size: frame_done pulsed with no finished frame to report");
		end

	assert property (@(posedge clk) disable iff (!resetn)
		frame_done && size_avail |-> {frame_width, frame_height} == size_head)
		else begin
			err_size++;
			$display("** Error frame_size: expected %0dx%0d, actual %0dx%0d",
				$sampled(size_head[2*DIM_WIDTH-1:DIM_WIDTH]), $sampled(size_head[DIM_WIDTH-1:0]),
				$sampled(frame_width), $sampled(frame_height));
		end

	assert property (@(posedge clk) disable iff (!resetn)
		size_error == exp_err)
		else begin
			err_ragged++;
			$display("** Error ragged: expected %b, actual %b",
				$sampled(exp_err), $sampled(size_error));
		end

	// During reset and the first cycle after it
	assert property (@(posedge clk)
		reset_check |-> !(m_axis_tvalid || frame_done || size_error))
		else begin
			err_reset++;
			$display("** Error reset: expected 000, actual %b%b%b",
				$sampled(m_axis_tvalid), $sampled(frame_done), $sampled(size_error));
		end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles > total_pixels() * 8) begin
			$display("timeout: stream did not drain within %0d cycles", cycles);
			$display("test failed");
			$finish;
		end
	end

	task automatic advance_cycle();
		@(negedge clk);
		rng = xorshift32(rng);
		m_axis_tready = rng[5:4] != 2'b00; // Ready three cycles in four
	endtask

	// Holds the beat until the slice takes it
	task automatic send_beat(input logic [PIXEL_WIDTH-1:0] data, input logic user,
		input logic last);
		logic done;
		logic first;
		done = 1'b0;
		first = 1'b1;
		while (!done) begin
			advance_cycle();
			s_axis_tdata = data;
			s_axis_tuser = user;
			s_axis_tlast = last;
			if (first || !s_axis_tvalid)
				s_axis_tvalid = rng[1:0] != 2'b00;
			first = 1'b0;
			done = s_axis_tvalid && s_axis_tready;
		end
	endtask

	task automatic report_result(input string name, input int errs);
		if (errs == 0) begin
			$display("%s: ok", name);
			n_pass++;
		end else begin
			$display("%s: FAILED with %0d errors", name, errs);
			n_fail++;
		end
	endtask

	initial begin
		int frames_left;
		rng = SEED;
		resetn = 1'b0;
		reset_check = 1'b0;
		s_axis_tdata = '0;
		s_axis_tuser = 1'b0;
		s_axis_tlast = 1'b0;
		s_axis_tvalid = 1'b0;
		m_axis_tready = 1'b1;
		@(negedge clk);
		reset_check = 1'b1;
		@(negedge clk);
		resetn = 1'b1;
		@(negedge clk);
		@(negedge clk);
		reset_check = 1'b0;

		for (int f = 0; f < NUM_FRAMES; f++)
			for (int r = 0; r < FRAME_H[f]; r++)
				for (int c = 0; c < line_width(f, r); c++)
					send_beat(pixel_value(r, c), r == 0 && c == 0, c == line_width(f, r) - 1);
		advance_cycle();
		s_axis_tvalid = 1'b0;

		// Missing pixels keep this loop busy until the cycle limit
		while (exp_q.size() != 0)
			advance_cycle();
		repeat (16) advance_cycle(); // Room for stray beats

		frames_left = size_q.size();
		if (frames_left != 0)
			$display("frame_size: %0d frame_done pulses never came", frames_left);

		report_result("site_select", err_site);
		report_result("flags", err_flags);
		report_result("backpressure", err_stall);
		report_result("frame_size", err_size + frames_left);
		report_result("ragged", err_ragged);
		report_result("reset", err_reset);
		$display("summary: %0d passed, %0d failed", n_pass, n_fail);
		if (n_fail == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

// File: list.f
logic/video_pkg.sv
logic/bayer_pkg.sv
logic/axis_register_slice.sv
logic/axis_bayer_extractor.sv
logic/bayer_frame_monitor.sv
logic/bayer_extract_top.sv
tb/tb_bayer_extract.sv

// File: run.sh
#!/bin/sh
# Build with Verilator, run, and judge the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_bayer_extract -f list.f -o sim_bayer \
	&& ./obj_dir/sim_bayer | tee sim.log \
	&& grep -q "^test passed$" sim.log \
	&& echo "simulation PASS" \
	|| { echo "simulation FAIL"; exit 1; }
